// File: compile.f
logic/decodePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/operandForward.sv
logic/branchResolve.sv
logic/decodeStage.sv
testbench/decodeStage_asserts.sv
testbench/decodeStageTb.sv

// File: logic/branchResolve.sv
// Branch and jump resolution in decode, all comparisons signed
// Jumps count as taken so the fetched instruction gets nulled
module branchResolve (
	input decodePkg::instr_t instr,
	input decodePkg::ctrl_t ctrl,
	input decodePkg::word_t fwdA,
	input decodePkg::word_t fwdB,
	input decodePkg::word_t pca,
	input decodePkg::word_t cia,
	output logic taken,
	output decodePkg::word_t nextPc
);
	import decodePkg::*;

	logic cond;
	word_t offset;
	word_t branchTarget;
	word_t jumpTarget;

	// -------------------------------------------------------------------------
	// Condition
	// -------------------------------------------------------------------------
	always_comb begin
		case (instr.i.opcode)
			OpBeq:  cond = (fwdA == fwdB);
			OpBne:  cond = (fwdA != fwdB);
			OpBlez: cond = ($signed(fwdA) <= 0);
			OpBgtz: cond = ($signed(fwdA) > 0);
			OpRegimm: begin
				case (instr.i.rt)
					RtBltz, RtBltzal: cond = ($signed(fwdA) < 0);
					RtBgez, RtBgezal: cond = ($signed(fwdA) >= 0);
					default:          cond = 1'b0;
				endcase
			end
			default: cond = 1'b0;
		endcase
	end

	assign taken = ctrl.jump | (ctrl.branch & cond);

	// -------------------------------------------------------------------------
	// Targets
	// -------------------------------------------------------------------------
	assign offset = {{(DataWidth-18){instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign branchTarget = pca + offset;
	assign jumpTarget = {cia[31:28], instr.j.index26, 2'b00};  // Region of current instr

	always_comb begin
		if (ctrl.jump && ctrl.jumpIndex) begin
			nextPc = jumpTarget;
		end else if (ctrl.jump) begin
			nextPc = fwdA;                  // JR, JALR
		end else if (taken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pca;
		end
	end

endmodule

// File: logic/decodePkg.sv
// Shared types and encodings for the MIPS-style decode stage
// ALU codes follow the execute stage encoding; 6-bit opcode and funct fields only
package decodePkg;

	// -------------------------------------------------------------------------
	// Widths and fixed registers
	// -------------------------------------------------------------------------
	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int RegCount = 2 ** RegAddrWidth;
	localparam int SyscallBubbles = 3;
	localparam int BubbleCntWidth = $clog2(SyscallBubbles + 1);

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;
	typedef logic [5:0] aluCtrl_t;

	localparam regAddr_t LinkReg = 5'd31;     // Return address register
	localparam regAddr_t SysArgReg = 5'd2;    // Syscall code lives in v0
	localparam word_t LinkOffset = 32'd4;

	// -------------------------------------------------------------------------
	// Opcode, funct and REGIMM rt codes
	// -------------------------------------------------------------------------
	localparam logic [5:0] OpSpecial = 6'h00, OpRegimm = 6'h01, OpJ = 6'h02, OpJal = 6'h03;
	localparam logic [5:0] OpBeq = 6'h04, OpBne = 6'h05, OpBlez = 6'h06, OpBgtz = 6'h07;
	localparam logic [5:0] OpAddi = 6'h08, OpAddiu = 6'h09, OpSlti = 6'h0a, OpSltiu = 6'h0b;
	localparam logic [5:0] OpAndi = 6'h0c, OpOri = 6'h0d, OpXori = 6'h0e, OpLui = 6'h0f;
	localparam logic [5:0] OpLb = 6'h20, OpLh = 6'h21, OpLw = 6'h23, OpLbu = 6'h24;
	localparam logic [5:0] OpLhu = 6'h25, OpSb = 6'h28, OpSh = 6'h29, OpSw = 6'h2b;

	localparam logic [5:0] FnSll = 6'h00, FnSrl = 6'h02, FnSra = 6'h03, FnSllv = 6'h04;
	localparam logic [5:0] FnSrlv = 6'h06, FnSrav = 6'h07, FnJr = 6'h08, FnJalr = 6'h09;
	localparam logic [5:0] FnSyscall = 6'h0c, FnAdd = 6'h20, FnAddu = 6'h21, FnSub = 6'h22;
	localparam logic [5:0] FnSubu = 6'h23, FnAnd = 6'h24, FnOr = 6'h25, FnXor = 6'h26;
	localparam logic [5:0] FnNor = 6'h27, FnSlt = 6'h2a, FnSltu = 6'h2b;

	localparam regAddr_t RtBltz = 5'h00, RtBgez = 5'h01, RtBltzal = 5'h10, RtBgezal = 5'h11;

	// -------------------------------------------------------------------------
	// ALU control codes
	// -------------------------------------------------------------------------
	localparam aluCtrl_t AluAdd = 6'b000001, AluAddu = 6'b110111, AluSub = 6'b011101;
	localparam aluCtrl_t AluSubu = 6'b011110, AluAnd = 6'b000100, AluOr = 6'b010000;
	localparam aluCtrl_t AluXor = 6'b011111, AluNor = 6'b001111, AluSlt = 6'b010101;
	localparam aluCtrl_t AluSltu = 6'b111111, AluSll = 6'b010011, AluSrl = 6'b011011;
	localparam aluCtrl_t AluSra = 6'b011001, AluSllv = 6'b010100, AluSrlv = 6'b011100;
	localparam aluCtrl_t AluSrav = 6'b011010, AluLui = 6'b001000;

	// Branch compare and jump codes
	localparam aluCtrl_t AluBeq = 6'b100010, AluBne = 6'b101001, AluBlez = 6'b100110;
	localparam aluCtrl_t AluBgtz = 6'b100101, AluBltz = 6'b100111, AluBgez = 6'b100011;
	localparam aluCtrl_t AluJump = 6'b001110, AluJr = 6'b111110;

	// Memory access size codes, address computed as an add
	localparam aluCtrl_t AluLb = 6'b100001, AluLh = 6'b101011, AluLw = 6'b111101;
	localparam aluCtrl_t AluLbu = 6'b101010, AluLhu = 6'b101100, AluSb = 6'b101111;
	localparam aluCtrl_t AluSh = 6'b110000, AluSw = 6'b110001;

	// -------------------------------------------------------------------------
	// Instruction formats
	// -------------------------------------------------------------------------
	typedef struct packed {
		logic [5:0] opcode;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		regAddr_t rs;
		regAddr_t rt;
		logic [15:0] imm16;
	} iFmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] index26;
	} jFmt_t;

	typedef union packed {
		rFmt_t r;
		iFmt_t i;
		jFmt_t j;
	} instr_t;

	// -------------------------------------------------------------------------
	// Bundles
	// -------------------------------------------------------------------------
	typedef struct packed {
		logic link;
		logic regDst;
		logic jump;
		logic branch;
		logic memRead;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regWrite;
		logic jumpIndex;    // Target from index26, not a register
		logic signExt;
		logic syscall;
		aluCtrl_t aluCtrl;
	} ctrl_t;

	typedef struct packed {
		logic writeback;
		regAddr_t dest;
		word_t data;
	} fwdSrc_t;

	typedef struct packed {
		word_t opA;
		word_t opB;
		regAddr_t dest;
		logic writeback;
		logic takenBranch;
		logic memRead;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		aluCtrl_t aluCtrl;
		regAddr_t srcA;     // Read indices for EX-stage forwarding
		regAddr_t srcB;
		logic [4:0] shamt;
	} idEx_t;

endpackage

// File: logic/decodeStage.sv
// Decode stage top: operand select, syscall bubbles and the ID/EX register
// Upstream must hold instr while insertBubble is high; FREEZE holds everything
module decodeStage (
	input logic CLK,
	input logic RESET,
	input logic FREEZE,
	input decodePkg::instr_t instr,
	input decodePkg::word_t pca,
	input decodePkg::word_t cia,
	input decodePkg::fwdSrc_t exFwd,
	input decodePkg::fwdSrc_t memFwd,
	input decodePkg::fwdSrc_t wbFwd,
	input decodePkg::word_t wbData,
	output decodePkg::idEx_t idEx,
	output decodePkg::word_t nextPc,
	output logic fetchNull,
	output logic insertBubble,
	output logic sysPulse
);
	import decodePkg::*;

	ctrl_t ctrl;
	word_t rdA;
	word_t rdB;
	word_t sysArg;
	word_t fwdA;
	word_t fwdB;
	word_t imm;
	logic taken;
	regAddr_t dest;
	idEx_t idExNext;
	logic [BubbleCntWidth-1:0] bubbleCnt;

	instrDecoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	regFile u_regFile (
		.CLK    (CLK),
		.srcA   (instr.r.rs),
		.srcB   (instr.r.rt),
		.wb     (wbFwd),
		.wbData (wbData),
		.rdA    (rdA),
		.rdB    (rdB),
		.sysArg (sysArg)
	);

	operandForward u_forward (
		.srcA   (instr.r.rs),
		.srcB   (instr.r.rt),
		.rdA    (rdA),
		.rdB    (rdB),
		.exFwd  (exFwd),
		.memFwd (memFwd),
		.wbFwd  (wbFwd),
		.fwdA   (fwdA),
		.fwdB   (fwdB)
	);

	branchResolve u_branch (
		.instr  (instr),
		.ctrl   (ctrl),
		.fwdA   (fwdA),
		.fwdB   (fwdB),
		.pca    (pca),
		.cia    (cia),
		.taken  (taken),
		.nextPc (nextPc)
	);

	assign fetchNull = taken;

	// -------------------------------------------------------------------------
	// Destination and operands
	// -------------------------------------------------------------------------
	assign imm = ctrl.signExt ? {{(DataWidth-16){instr.i.imm16[15]}}, instr.i.imm16}
	                          : {{(DataWidth-16){1'b0}}, instr.i.imm16};

	always_comb begin
		if (ctrl.regDst)       dest = instr.r.rd;
		else if (ctrl.link)    dest = LinkReg;
		else if (ctrl.syscall) dest = '0;
		else                   dest = instr.i.rt;
	end

	always_comb begin
		idExNext = '0;
		idExNext.opA = ctrl.link ? pca : (ctrl.syscall ? sysArg : rdA);
		if (ctrl.link)         idExNext.opB = LinkOffset;
		else if (ctrl.syscall) idExNext.opB = '0;
		else if (ctrl.aluSrc)  idExNext.opB = imm;
		else                   idExNext.opB = rdB;
		idExNext.dest = dest;
		idExNext.writeback = (ctrl.regWrite && (dest != '0)) || ctrl.memToReg;
		idExNext.takenBranch = taken;
		idExNext.memRead = ctrl.memRead;
		idExNext.memToReg = ctrl.memToReg;
		idExNext.memWrite = ctrl.memWrite;
		idExNext.aluSrc = ctrl.aluSrc;
		idExNext.aluCtrl = ctrl.aluCtrl;
		idExNext.srcA = (ctrl.link || ctrl.syscall) ? '0 : instr.r.rs;
		idExNext.srcB = (ctrl.aluSrc || ctrl.link || ctrl.syscall) ? '0 : instr.r.rt;
		idExNext.shamt = instr.r.shamt;
	end

	// -------------------------------------------------------------------------
	// Syscall bubbles and ID/EX register
	// -------------------------------------------------------------------------
	assign insertBubble = ctrl.syscall && (bubbleCnt != '0);
	assign sysPulse = ctrl.syscall && (bubbleCnt == '0);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			bubbleCnt <= BubbleCntWidth'(SyscallBubbles);
		end else if (!FREEZE) begin
			if (insertBubble) begin
				bubbleCnt <= bubbleCnt - 1'b1;
			end else begin
				bubbleCnt <= BubbleCntWidth'(SyscallBubbles);  // Reload after the pulse
			end
		end
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			idEx <= '0;
		end else if (!FREEZE) begin
			idEx <= insertBubble ? '0 : idExNext;   // Bubble is a zero bundle
		end
	end

endmodule

// File: logic/instrDecoder.sv
// Integer MIPS-I subset only; no coprocessor, HI/LO, unaligned or likely branches
// Anything unrecognised decodes to an all-zero bundle and acts as a NOP
module instrDecoder (
	input decodePkg::instr_t instr,
	output decodePkg::ctrl_t ctrl
);
	import decodePkg::*;

	// Register-register op, result to rd
	function automatic ctrl_t rOp(input aluCtrl_t code);
		ctrl_t c;
		c = '0;
		c.regDst = 1'b1;
		c.regWrite = 1'b1;
		c.aluCtrl = code;
		return c;
	endfunction

	// Immediate op, result to rt
	function automatic ctrl_t iOp(input aluCtrl_t code, input logic sext);
		ctrl_t c;
		c = '0;
		c.aluSrc = 1'b1;
		c.regWrite = 1'b1;
		c.signExt = sext;
		c.aluCtrl = code;
		return c;
	endfunction

	function automatic ctrl_t brOp(input aluCtrl_t code);
		ctrl_t c;
		c = '0;
		c.branch = 1'b1;
		c.signExt = 1'b1;   // Offset is signed
		c.aluCtrl = code;
		return c;
	endfunction

	function automatic ctrl_t ldOp(input aluCtrl_t code);
		ctrl_t c;
		c = iOp(code, 1'b1);
		c.memRead = 1'b1;
		c.memToReg = 1'b1;
		return c;
	endfunction

	function automatic ctrl_t stOp(input aluCtrl_t code);
		ctrl_t c;
		c = '0;
		c.aluSrc = 1'b1;
		c.signExt = 1'b1;
		c.memWrite = 1'b1;
		c.aluCtrl = code;
		return c;
	endfunction

	always_comb begin
		ctrl = '0;
		case (instr.r.opcode)
			OpSpecial: begin
				case (instr.r.funct)
					FnSll:  ctrl = rOp(AluSll);
					FnSrl:  ctrl = rOp(AluSrl);
					FnSra:  ctrl = rOp(AluSra);
					FnSllv: ctrl = rOp(AluSllv);
					FnSrlv: ctrl = rOp(AluSrlv);
					FnSrav: ctrl = rOp(AluSrav);
					FnAdd:  ctrl = rOp(AluAdd);
					FnAddu: ctrl = rOp(AluAddu);
					FnSub:  ctrl = rOp(AluSub);
					FnSubu: ctrl = rOp(AluSubu);
					FnAnd:  ctrl = rOp(AluAnd);
					FnOr:   ctrl = rOp(AluOr);
					FnXor:  ctrl = rOp(AluXor);
					FnNor:  ctrl = rOp(AluNor);
					FnSlt:  ctrl = rOp(AluSlt);
					FnSltu: ctrl = rOp(AluSltu);
					FnJr: begin
						ctrl.jump = 1'b1;
						ctrl.aluCtrl = AluJr;
					end
					FnJalr: begin
						ctrl = rOp(AluAdd);         // Link value pca + 4 into rd
						ctrl.link = 1'b1;
						ctrl.jump = 1'b1;
					end
					FnSyscall: begin
						ctrl = iOp(AluAdd, 1'b1);
						ctrl.syscall = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			OpRegimm: begin
				case (instr.i.rt)
					RtBltz: ctrl = brOp(AluBltz);
					RtBgez: ctrl = brOp(AluBgez);
					RtBltzal, RtBgezal: begin
						ctrl = brOp(AluAdd);        // ALU forms the link value
						ctrl.link = 1'b1;
						ctrl.regWrite = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			OpJ: begin
				ctrl.jump = 1'b1;
				ctrl.jumpIndex = 1'b1;
				ctrl.aluCtrl = AluJump;
			end
			OpJal: begin
				ctrl.link = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.jumpIndex = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluCtrl = AluAdd;
			end
			OpBeq:   ctrl = brOp(AluBeq);
			OpBne:   ctrl = brOp(AluBne);
			OpBlez:  ctrl = brOp(AluBlez);
			OpBgtz:  ctrl = brOp(AluBgtz);
			OpAddi:  ctrl = iOp(AluAdd, 1'b1);
			OpAddiu: ctrl = iOp(AluAddu, 1'b1);
			OpSlti:  ctrl = iOp(AluSlt, 1'b1);
			OpSltiu: ctrl = iOp(AluSltu, 1'b1);   // Sign-extended, compared unsigned
			OpAndi:  ctrl = iOp(AluAnd, 1'b0);
			OpOri:   ctrl = iOp(AluOr, 1'b0);
			OpXori:  ctrl = iOp(AluXor, 1'b0);
			OpLui:   ctrl = iOp(AluLui, 1'b0);
			OpLb:    ctrl = ldOp(AluLb);
			OpLh:    ctrl = ldOp(AluLh);
			OpLw:    ctrl = ldOp(AluLw);
			OpLbu:   ctrl = ldOp(AluLbu);
			OpLhu:   ctrl = ldOp(AluLhu);
			OpSb:    ctrl = stOp(AluSb);
			OpSh:    ctrl = stOp(AluSh);
			OpSw:    ctrl = stOp(AluSw);
			default: ctrl = '0;
		endcase
	end

endmodule

// File: logic/operandForward.sv
// Forwarded operands for the branch compare and jump-register target only
// Priority EX over MEM over WB; a source needs writeback set and a matching dest
module operandForward (
	input decodePkg::regAddr_t srcA,
	input decodePkg::regAddr_t srcB,
	input decodePkg::word_t rdA,
	input decodePkg::word_t rdB,
	input decodePkg::fwdSrc_t exFwd,
	input decodePkg::fwdSrc_t memFwd,
	input decodePkg::fwdSrc_t wbFwd,
	output decodePkg::word_t fwdA,
	output decodePkg::word_t fwdB
);
	import decodePkg::*;

	function automatic logic hit(input fwdSrc_t s, input regAddr_t idx);
		return s.writeback && (s.dest == idx);
	endfunction

	// One read port through the priority chain
	function automatic word_t pick(
		input regAddr_t idx,
		input word_t regVal,
		input fwdSrc_t ex,
		input fwdSrc_t mem,
		input fwdSrc_t wb
	);
		word_t v;
		if (hit(ex, idx)) begin
			v = ex.data;        // Live ALU result
		end else if (hit(mem, idx)) begin
			v = mem.data;
		end else if (hit(wb, idx)) begin
			v = wb.data;
		end else begin
			v = regVal;
		end
		return v;
	endfunction

	assign fwdA = pick(srcA, rdA, exFwd, memFwd, wbFwd);
	assign fwdB = pick(srcB, rdB, exFwd, memFwd, wbFwd);

endmodule

// File: logic/regFile.sv
// 32 x 32 register file, contents undefined until written
// Write lands on the clock edge; same-cycle reads see the old value
module regFile (
	input logic CLK,
	input decodePkg::regAddr_t srcA,
	input decodePkg::regAddr_t srcB,
	input decodePkg::fwdSrc_t wb,
	input decodePkg::word_t wbData,
	output decodePkg::word_t rdA,
	output decodePkg::word_t rdB,
	output decodePkg::word_t sysArg
);
	import decodePkg::*;

	word_t regs [RegCount];

	// Writeback port
	always_ff @(posedge CLK) begin
		if (wb.writeback) begin
			regs[wb.dest] <= wbData;
		end
	end

	// Asynchronous reads
	assign rdA = regs[srcA];
	assign rdB = regs[srcB];
	assign sysArg = regs[SysArgReg];  // Syscall operand tap

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module decodeStageTb \
	-Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
echo "Simulation passed"
exit 0

// File: testbench/decodeStageTb.sv
// Decode stage testbench, one instruction per cycle, registers preloaded via wbFwd
// Expected values come from a reference model of the decode rules and a shadow register file
module decodeStageTb;
	timeunit 1ns;
	timeprecision 1ps;
	import decodePkg::*;

	localparam int NumSteps = 36 + 30 + 6 + 2;     // ALU, branch, jump and sequence tests
	localparam int TimeoutCycles = NumSteps * 6 + 100;
	localparam logic [5:0] RFns [16] = '{FnSll, FnSrl, FnSra, FnSllv, FnSrlv, FnSrav,
		FnAdd, FnAddu, FnSub, FnSubu, FnAnd, FnOr, FnXor, FnNor, FnSlt, FnSltu};
	localparam logic [5:0] ImmOps [8] = '{OpAddi, OpAddiu, OpSlti, OpSltiu,
		OpAndi, OpOri, OpXori, OpLui};
	localparam logic [5:0] MemOps [8] = '{OpLb, OpLh, OpLw, OpLbu, OpLhu, OpSb, OpSh, OpSw};
	localparam logic [5:0] BrOps [4] = '{OpBeq, OpBne, OpBlez, OpBgtz};

	logic CLK = 1'b0;
	logic RESET;
	logic FREEZE;
	instr_t instr;
	word_t pca;
	word_t cia;
	fwdSrc_t exFwd;
	fwdSrc_t memFwd;
	fwdSrc_t wbFwd;
	word_t wbData;
	idEx_t idEx;
	word_t nextPc;
	logic fetchNull;
	logic insertBubble;
	logic sysPulse;

	word_t shadow [RegCount];
	int cycleCount = 0;

	// Handoff from stimulus to the compare process
	string testName;
	string heldName;
	idEx_t expIdEx;
	idEx_t heldIdEx;
	word_t expNextPc;
	logic expTaken;
	logic combDue = 1'b0;
	logic idExDue = 1'b0;

	decodeStage u_dut (.*);

	always #20 CLK = ~CLK;

	// -------------------------------------------------------------------------
	// Failure reporting and compare tasks
	// -------------------------------------------------------------------------
	task automatic failRun();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input string what, input word_t exp,
		input word_t act);
		if (act !== exp) begin
			$display("ERROR %s %s expected %h actual %h", name, what, exp, act);
			failRun();
		end
	endtask

	task automatic checkBit(input string name, input string what, input logic exp,
		input logic act);
		if (act !== exp) begin
			$display("ERROR %s %s expected %b actual %b", name, what, exp, act);
			failRun();
		end
	endtask

	task automatic checkIdEx(input string name, input idEx_t exp, input idEx_t act);
		if (act !== exp) begin
			$display("ERROR %s idEx expected %h actual %h", name, exp, act);
			failRun();
		end
	endtask

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			failRun();
		end
	end

	// Comb outputs checked mid-cycle, idEx one cycle later
	always @(negedge CLK) begin
		if (idExDue) begin
			checkIdEx(heldName, heldIdEx, idEx);
			idExDue = 1'b0;
		end
		if (combDue) begin
			checkWord(testName, "nextPc", expNextPc, nextPc);
			checkBit(testName, "fetchNull", expTaken, fetchNull);
			heldIdEx = expIdEx;
			heldName = testName;
			idExDue = 1'b1;
			combDue = 1'b0;
		end
	end

	// -------------------------------------------------------------------------
	// Reference model
	// -------------------------------------------------------------------------
	function automatic word_t forwardedValue(input regAddr_t idx, input fwdSrc_t ex,
		input fwdSrc_t mem, input fwdSrc_t wb);
		if (ex.writeback && ex.dest == idx) return ex.data;
		if (mem.writeback && mem.dest == idx) return mem.data;
		if (wb.writeback && wb.dest == idx) return wb.data;
		return shadow[idx];
	endfunction

	function automatic aluCtrl_t rTypeCode(input logic [5:0] fn);
		case (fn)
			FnSll:  return AluSll;
			FnSrl:  return AluSrl;
			FnSra:  return AluSra;
			FnSllv: return AluSllv;
			FnSrlv: return AluSrlv;
			FnSrav: return AluSrav;
			FnAdd:  return AluAdd;
			FnAddu: return AluAddu;
			FnSub:  return AluSub;
			FnSubu: return AluSubu;
			FnAnd:  return AluAnd;
			FnOr:   return AluOr;
			FnXor:  return AluXor;
			FnNor:  return AluNor;
			FnSlt:  return AluSlt;
			FnSltu: return AluSltu;
			default: return '0;
		endcase
	endfunction

	function automatic void expectIdEx(input instr_t in, input word_t pcAfter,
		input word_t pcCur, input fwdSrc_t ex, input fwdSrc_t mem, input fwdSrc_t wb,
		output idEx_t e, output word_t npc, output logic tk);
		logic lnk, rdst, useImm, sx, wr, jmp, jidx, br, sys, ld, st, cond;
		aluCtrl_t code;
		regAddr_t d;
		word_t a, b, immVal;
		{lnk, rdst, useImm, sx, wr, jmp, jidx, br, sys, ld, st, cond} = '0;
		code = '0;
		e = '0;
		a = forwardedValue(in.r.rs, ex, mem, wb);
		b = forwardedValue(in.r.rt, ex, mem, wb);
		case (in.r.opcode)
			OpSpecial: begin
				case (in.r.funct)
					FnJr: {jmp, code} = {1'b1, AluJr};
					FnJalr: {jmp, lnk, rdst, wr, code} = {4'b1111, AluAdd};
					FnSyscall: {sys, useImm, sx, wr, code} = {4'b1111, AluAdd};
					default: begin
						code = rTypeCode(in.r.funct);
						rdst = (code != '0);
						wr = rdst;
					end
				endcase
			end
			OpRegimm: begin
				{br, sx} = 2'b11;
				case (in.i.rt)
					RtBltz:   {code, cond} = {AluBltz, $signed(a) < 0};
					RtBgez:   {code, cond} = {AluBgez, $signed(a) >= 0};
					RtBltzal: {lnk, wr, code, cond} = {2'b11, AluAdd, $signed(a) < 0};
					RtBgezal: {lnk, wr, code, cond} = {2'b11, AluAdd, $signed(a) >= 0};
					default:  {br, sx} = 2'b00;
				endcase
			end
			OpJ:    {jmp, jidx, code} = {2'b11, AluJump};
			OpJal:  {jmp, jidx, lnk, wr, code} = {4'b1111, AluAdd};
			OpBeq:  {br, sx, code, cond} = {2'b11, AluBeq, a == b};
			OpBne:  {br, sx, code, cond} = {2'b11, AluBne, a != b};
			OpBlez: {br, sx, code, cond} = {2'b11, AluBlez, $signed(a) <= 0};
			OpBgtz: {br, sx, code, cond} = {2'b11, AluBgtz, $signed(a) > 0};
			OpAddi:  {useImm, wr, sx, code} = {3'b111, AluAdd};
			OpAddiu: {useImm, wr, sx, code} = {3'b111, AluAddu};
			OpSlti:  {useImm, wr, sx, code} = {3'b111, AluSlt};
			OpSltiu: {useImm, wr, sx, code} = {3'b111, AluSltu};
			OpAndi:  {useImm, wr, code} = {2'b11, AluAnd};
			OpOri:   {useImm, wr, code} = {2'b11, AluOr};
			OpXori:  {useImm, wr, code} = {2'b11, AluXor};
			OpLui:   {useImm, wr, code} = {2'b11, AluLui};
			OpLb:  {useImm, wr, sx, ld, code} = {4'b1111, AluLb};
			OpLh:  {useImm, wr, sx, ld, code} = {4'b1111, AluLh};
			OpLw:  {useImm, wr, sx, ld, code} = {4'b1111, AluLw};
			OpLbu: {useImm, wr, sx, ld, code} = {4'b1111, AluLbu};
			OpLhu: {useImm, wr, sx, ld, code} = {4'b1111, AluLhu};
			OpSb:  {useImm, sx, st, code} = {3'b111, AluSb};
			OpSh:  {useImm, sx, st, code} = {3'b111, AluSh};
			OpSw:  {useImm, sx, st, code} = {3'b111, AluSw};
			default: code = '0;
		endcase

		tk = jmp | (br & cond);
		if (jmp && jidx) npc = {pcCur[31:28], in.j.index26, 2'b00};
		else if (jmp) npc = a;
		else if (tk) npc = pcAfter + {{14{in.i.imm16[15]}}, in.i.imm16, 2'b00};
		else npc = pcAfter;

		if (rdst) d = in.r.rd;
		else if (lnk) d = LinkReg;
		else if (sys) d = '0;
		else d = in.i.rt;
		immVal = sx ? {{16{in.i.imm16[15]}}, in.i.imm16} : {16'h0000, in.i.imm16};

		// Stored operands are unforwarded register reads
		e.opA = lnk ? pcAfter : (sys ? shadow[SysArgReg] : shadow[in.r.rs]);
		e.opB = lnk ? LinkOffset : (sys ? '0 : (useImm ? immVal : shadow[in.r.rt]));
		e.dest = d;
		e.writeback = (wr && d != '0) || ld;
		e.takenBranch = tk;
		e.memRead = ld;
		e.memToReg = ld;
		e.memWrite = st;
		e.aluSrc = useImm;
		e.aluCtrl = code;
		e.srcA = (lnk || sys) ? '0 : in.r.rs;
		e.srcB = (useImm || lnk || sys) ? '0 : in.r.rt;
		e.shamt = in.r.shamt;
	endfunction

	// -------------------------------------------------------------------------
	// Stimulus helpers
	// -------------------------------------------------------------------------
	function automatic instr_t makeR(input logic [5:0] fn, input regAddr_t rs,
		input regAddr_t rt, input regAddr_t rd, input logic [4:0] sh);
		return {OpSpecial, rs, rt, rd, sh, fn};
	endfunction

	function automatic instr_t makeI(input logic [5:0] op, input regAddr_t rs,
		input regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic fwdSrc_t mkFwd(input logic w, input regAddr_t d, input word_t v);
		return '{writeback: w, dest: d, data: v};
	endfunction

	function automatic regAddr_t pickReg();
		return regAddr_t'(1 + $urandom_range(30));   // Never register 0
	endfunction

	task automatic applyInstr(input string name, input instr_t in, input fwdSrc_t ex,
		input fwdSrc_t mem, input fwdSrc_t wb);
		word_t pcCur;
		pcCur = $urandom() & 32'hffff_fffc;
		@(posedge CLK);
		instr <= in;
		cia <= pcCur;
		pca <= pcCur + 32'd4;
		exFwd <= ex;
		memFwd <= mem;
		wbFwd <= wb;
		wbData <= wb.data;
		expectIdEx(in, pcCur + 32'd4, pcCur, ex, mem, wb, expIdEx, expNextPc, expTaken);
		testName = name;
		combDue = 1'b1;
		if (wb.writeback) shadow[wb.dest] = wb.data;   // Lands on the next edge
	endtask

	task automatic drainChecks();
		@(posedge CLK);
		wbFwd <= '0;
		repeat (2) @(negedge CLK);
	endtask

	task automatic loadRegisters();
		word_t v;
		for (int r = 0; r < RegCount; r++) begin
			v = (r == 0) ? '0 : $urandom();
			@(posedge CLK);
			wbFwd <= mkFwd(1'b1, regAddr_t'(r), v);
			wbData <= v;
			shadow[r] = v;
		end
		@(posedge CLK);
		wbFwd <= '0;
	endtask

	// -------------------------------------------------------------------------
	// Test groups
	// -------------------------------------------------------------------------
	task automatic aluTests();
		fwdSrc_t none;
		none = '0;
		for (int i = 0; i < 16; i++) begin
			applyInstr("rtype", makeR(RFns[i], pickReg(), pickReg(),
				regAddr_t'($urandom_range(31)), 5'($urandom())), none, none, none);
		end
		applyInstr("add_to_r0", makeR(FnAdd, pickReg(), pickReg(), '0, '0), none, none, none);
		applyInstr("addi_to_r0", makeI(OpAddi, pickReg(), '0, 16'h1234), none, none, none);
		for (int i = 0; i < 8; i++) begin
			applyInstr("imm", makeI(ImmOps[i], pickReg(), pickReg(), 16'($urandom())),
				none, none, none);
		end
		applyInstr("addi_sext", makeI(OpAddi, pickReg(), pickReg(), 16'hff80), none, none, none);
		applyInstr("ori_zext", makeI(OpOri, pickReg(), pickReg(), 16'hf00f), none, none, none);
		for (int i = 0; i < 8; i++) begin
			applyInstr("mem", makeI(MemOps[i], pickReg(), regAddr_t'($urandom_range(31)),
				16'($urandom())), none, none, none);
		end
	endtask

	// Sources alone, then EX over MEM and WB on rs, then MEM over WB on rt
	task automatic branchTests();
		regAddr_t rs, rt;
		word_t v;
		instr_t in;
		fwdSrc_t ex, mem, wb;
		for (int op = 0; op < 6; op++) begin
			for (int c = 0; c < 5; c++) begin
				rs = pickReg();
				rt = pickReg();
				if (op < 4) in = makeI(BrOps[op], rs, rt, 16'($urandom()));
				else in = makeI(OpRegimm, rs, (op == 4) ? RtBltz : RtBgez, 16'($urandom()));
				v = $urandom_range(1) ? shadow[rt] : $urandom();
				ex = (c == 0 || c >= 3) ? mkFwd(1'b1, rs, v) : '0;
				case (c)
					1: mem = mkFwd(1'b1, rs, v);
					3: mem = mkFwd(1'b1, rs, $urandom());
					4: mem = mkFwd(1'b1, rt, v);
					default: mem = '0;
				endcase
				case (c)
					2: wb = mkFwd(1'b1, rs, v);
					3: wb = mkFwd(1'b1, rs, $urandom());
					4: wb = mkFwd(1'b1, rt, $urandom());
					default: wb = '0;
				endcase
				applyInstr("branch", in, ex, mem, wb);
			end
		end
	endtask

	task automatic jumpTests();
		fwdSrc_t none;
		regAddr_t rs;
		none = '0;
		applyInstr("j", {OpJ, 26'($urandom())}, none, none, none);
		rs = pickReg();
		applyInstr("jr", makeR(FnJr, rs, '0, '0, '0), mkFwd(1'b1, rs, $urandom()), none, none);
		applyInstr("jal", {OpJal, 26'($urandom())}, none, none, none);
		rs = pickReg();
		applyInstr("jalr", makeR(FnJalr, rs, '0, pickReg(), '0), none,
			mkFwd(1'b1, rs, $urandom()), none);
		applyInstr("bgezal", makeI(OpRegimm, pickReg(), RtBgezal, 16'($urandom())),
			none, none, none);
		applyInstr("bltzal", makeI(OpRegimm, pickReg(), RtBltzal, 16'($urandom())),
			none, none, none);
	endtask

	// Three unfrozen bubble edges with a two-cycle freeze after the first
	task automatic syscallTest();
		instr_t sys;
		idEx_t e;
		word_t npc;
		logic tk;
		sys = makeR(FnSyscall, '0, '0, '0, '0);
		@(posedge CLK);
		instr <= sys;
		exFwd <= '0;
		memFwd <= '0;
		expectIdEx(sys, pca, cia, '0, '0, '0, e, npc, tk);
		@(negedge CLK);
		checkBit("syscall", "insertBubble", 1'b1, insertBubble);
		@(posedge CLK);
		FREEZE <= 1'b1;
		for (int n = 0; n < 2; n++) begin
			@(negedge CLK);
			checkBit("syscall_frozen", "insertBubble", 1'b1, insertBubble);
			checkIdEx("syscall_frozen", '0, idEx);
			@(posedge CLK);
		end
		FREEZE <= 1'b0;
		@(negedge CLK);
		checkBit("syscall", "insertBubble", 1'b1, insertBubble);
		@(posedge CLK);
		@(negedge CLK);
		checkBit("syscall", "insertBubble", 1'b1, insertBubble);
		checkIdEx("syscall_bubble", '0, idEx);
		@(posedge CLK);
		@(negedge CLK);
		checkBit("syscall", "insertBubble", 1'b0, insertBubble);
		checkBit("syscall", "sysPulse", 1'b1, sysPulse);
		checkIdEx("syscall_bubble", '0, idEx);
		@(posedge CLK);
		@(negedge CLK);
		checkIdEx("syscall_enter", e, idEx);
		checkBit("syscall_enter", "sysPulse", 1'b0, sysPulse);
		checkBit("syscall_enter", "insertBubble", 1'b1, insertBubble);   // Counter reloaded
	endtask

	task automatic freezeResetTest();
		instr_t add;
		idEx_t e;
		word_t npc;
		logic tk;
		add = makeR(FnAdd, pickReg(), pickReg(), pickReg(), '0);
		@(posedge CLK);
		instr <= add;
		expectIdEx(add, pca, cia, '0, '0, '0, e, npc, tk);
		@(posedge CLK);
		FREEZE <= 1'b1;
		instr <= makeR(FnSyscall, '0, '0, '0, '0);   // Would bubble if not frozen
		repeat (2) begin
			@(negedge CLK);
			checkIdEx("freeze_hold", e, idEx);
		end
		@(posedge CLK);
		FREEZE <= 1'b0;
		RESET <= 1'b0;
		@(negedge CLK);
		checkIdEx("reset", '0, idEx);
		checkBit("reset", "insertBubble", 1'b1, insertBubble);
		checkBit("reset", "sysPulse", 1'b0, sysPulse);
		@(posedge CLK);
		RESET <= 1'b1;
	endtask

	initial begin
		void'($urandom(21));
		RESET = 1'b0;
		FREEZE = 1'b0;
		instr = '0;
		pca = 32'd4;
		cia = '0;
		exFwd = '0;
		memFwd = '0;
		wbFwd = '0;
		wbData = '0;
		repeat (10) @(posedge CLK);
		RESET <= 1'b1;
		@(negedge CLK);
		checkIdEx("after_reset", '0, idEx);
		loadRegisters();
		aluTests();
		branchTests();
		jumpTests();
		drainChecks();
		syscallTest();
		freezeResetTest();
		repeat (2) @(posedge CLK);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: testbench/decodeStage_asserts.sv
// Bubble, syscall and writeback rules on the decode stage outputs
// Checked only while RESET is released
module decodeStageAsserts (
	input logic CLK,
	input logic RESET,
	input logic FREEZE,
	input logic insertBubble,
	input logic sysPulse,
	input decodePkg::idEx_t idEx
);
	timeunit 1ns;
	timeprecision 1ps;
	import decodePkg::*;

	// Counter reloads once the syscall enters idEx
	assert property (@(posedge CLK) disable iff (!RESET) (sysPulse && !FREEZE) |=> !sysPulse)
		else $error("sysPulse held past the syscall entry");

	assert property (@(posedge CLK) disable iff (!RESET)
		(insertBubble && !FREEZE) |=> (idEx == '0))
		else $error("bubble did not clear idEx");

	assert property (@(posedge CLK) disable iff (!RESET) FREEZE |=> $stable(idEx))
		else $error("idEx changed while frozen");

	// Syscall lands with no register write
	assert property (@(posedge CLK) disable iff (!RESET)
		(sysPulse && !FREEZE) |=> (idEx.dest == '0 && !idEx.writeback))
		else $error("syscall bundle writes a register");

	assert property (@(posedge CLK) disable iff (!RESET)
		(idEx.writeback && !idEx.memToReg) |-> (idEx.dest != '0))
		else $error("writeback to register 0");

endmodule

bind decodeStage decodeStageAsserts u_asserts (
	.CLK          (CLK),
	.RESET        (RESET),
	.FREEZE       (FREEZE),
	.insertBubble (insertBubble),
	.sysPulse     (sysPulse),
	.idEx         (idEx)
);
